// ==== rtl/periph_consts.svh ====
// Address map, slot numbers, widths and reset pin selections of the peripheral wrapper
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus widths
`define PERIPH_ADDR_W       11
`define PERIPH_DATA_W       32
`define PERIPH_SLOT_OFS_W   6      // 64-byte word slots
`define PERIPH_BYTE_OFS_W   4      // 16-byte byte slots

// Access size strobe, active low
`define ACCESS_IDLE         2'b11

// Slot numbers
`define PERIPH_SLOT_GPIO    1
`define PERIPH_SLOT_MUL     2
`define PERIPH_BYTE_PWM     0

// GPIO register offsets
`define GPIO_OFS_OUT        6'h00
`define GPIO_OFS_IN         6'h04
`define GPIO_OFS_AUDIO      6'h10
`define GPIO_OFS_FSEL_BASE  6'h20  // Select n at base + 4n

// Multiplier register offsets and operand width
`define MUL_OFS_A           6'h00
`define MUL_OFS_B           6'h04
`define MUL_OFS_P           6'h08
`define MUL_OP_W            16

// Output pins and their reset function selects
`define PIN_COUNT           8
`define FSEL_RESET_LOW      5'(`PERIPH_SLOT_MUL)   // Pins 0 and 1
`define FSEL_RESET_HIGH     5'(`PERIPH_SLOT_GPIO)

`endif

// ==== rtl/periph_bus_pkg.sv ====
// Bus request, gated slot request and peripheral response types
`default_nettype none

`include "periph_consts.svh"

package periph_bus_pkg;

    // 11 idle, 00 byte, 01 halfword, 10 word
    typedef logic [1:0] access_n_t;

    // Request as issued by the core
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] data;
        access_n_t                 write_n;
        access_n_t                 read_n;
    } bus_req_t;

    // Request after decode, strobes idle unless this slot is addressed
    typedef struct packed {
        logic [`PERIPH_SLOT_OFS_W-1:0] ofs;
        logic [`PERIPH_DATA_W-1:0]     data;
        access_n_t                     write_n;
        access_n_t                     read_n;
    } slot_req_t;

    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] data;
        logic                      ready;    // Read data valid
    } periph_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/periph_map_pkg.sv ====
// Pin function select type and pin source bundle
`default_nettype none

`include "periph_consts.svh"

package periph_map_pkg;

    // Which slot drives an output pin
    typedef struct packed {
        logic       byte_sel;   // Byte slots rather than word slots
        logic [3:0] slot;
    } fsel_t;

    // Pin outputs offered by the peripherals
    typedef struct packed {
        logic [`PIN_COUNT-1:0] mul;
        logic [`PIN_COUNT-1:0] pwm;
    } pin_src_t;

endpackage

`default_nettype wire

// ==== rtl/periph_decode.sv ====
// Address decoder, request gating, response mux and read holding register
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module periph_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_bus_pkg::bus_req_t    i_req,
    input  logic                        i_read_complete,
    output periph_bus_pkg::slot_req_t   o_gpio_req,
    output periph_bus_pkg::slot_req_t   o_mul_req,
    output periph_bus_pkg::slot_req_t   o_pwm_req,
    input  periph_bus_pkg::periph_rsp_t i_gpio_rsp,
    input  periph_bus_pkg::periph_rsp_t i_mul_rsp,
    input  periph_bus_pkg::periph_rsp_t i_pwm_rsp,
    output logic [`PERIPH_DATA_W-1:0]   o_data,
    output logic                        o_data_ready
);

    logic [3:0]                     word_slot;
    logic [3:0]                     byte_slot;
    logic [`PERIPH_SLOT_OFS_W-1:0]  byte_ofs;
    logic                           gpio_hit;
    logic                           mul_hit;
    logic                           pwm_hit;
    logic                           read_req;
    logic                           capture;
    logic                           hold;       // Result waits for read complete
    logic                           ready_r;
    logic [`PERIPH_DATA_W-1:0]      data_r;
    logic [`PERIPH_DATA_W-1:0]      sel_data;
    logic                           sel_ready;
    periph_bus_pkg::access_n_t      read_n_peri;

    function automatic periph_bus_pkg::slot_req_t gate_req(
        input logic                          hit,
        input logic [`PERIPH_SLOT_OFS_W-1:0] ofs,
        input periph_bus_pkg::bus_req_t      req,
        input periph_bus_pkg::access_n_t     read_n
    );
        periph_bus_pkg::slot_req_t sreq;
        sreq.ofs     = ofs;
        sreq.data    = req.data;
        sreq.write_n = hit ? req.write_n : `ACCESS_IDLE;
        sreq.read_n  = hit ? read_n : `ACCESS_IDLE;
        return sreq;
    endfunction

    // Bit 10 picks the byte slots
    assign word_slot = i_req.addr[`PERIPH_ADDR_W-2:`PERIPH_SLOT_OFS_W];
    assign byte_slot = i_req.addr[`PERIPH_BYTE_OFS_W+3:`PERIPH_BYTE_OFS_W];
    assign byte_ofs  = {{(`PERIPH_SLOT_OFS_W-`PERIPH_BYTE_OFS_W){1'b0}},
                        i_req.addr[`PERIPH_BYTE_OFS_W-1:0]};

    assign gpio_hit = !i_req.addr[`PERIPH_ADDR_W-1] && word_slot == 4'(`PERIPH_SLOT_GPIO);
    assign mul_hit  = !i_req.addr[`PERIPH_ADDR_W-1] && word_slot == 4'(`PERIPH_SLOT_MUL);
    assign pwm_hit  = i_req.addr[`PERIPH_ADDR_W-1] && byte_slot == 4'(`PERIPH_BYTE_PWM);

    assign read_req    = i_req.read_n != `ACCESS_IDLE;
    assign read_n_peri = i_req.read_n | {2{hold}};   // No second read while holding

    assign o_gpio_req = gate_req(gpio_hit, i_req.addr[`PERIPH_SLOT_OFS_W-1:0], i_req,
                                 read_n_peri);
    assign o_mul_req  = gate_req(mul_hit, i_req.addr[`PERIPH_SLOT_OFS_W-1:0], i_req,
                                 read_n_peri);
    assign o_pwm_req  = gate_req(pwm_hit, byte_ofs, i_req, read_n_peri);

    always_comb begin
        sel_data  = '0;
        sel_ready = 1'b1;   // Empty slots read zero at once
        if (gpio_hit) begin
            sel_data  = i_gpio_rsp.data;
            sel_ready = i_gpio_rsp.ready;
        end else if (mul_hit) begin
            sel_data  = i_mul_rsp.data;
            sel_ready = i_mul_rsp.ready;
        end else if (pwm_hit) begin
            sel_data  = i_pwm_rsp.data;
            sel_ready = i_pwm_rsp.ready;
        end
    end

    assign capture = !hold && sel_ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;
            ready_r <= read_req && sel_ready;   // Follows the registered data
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_r <= sel_data;
    end

    assign o_data       = data_r;
    assign o_data_ready = ready_r || i_req.write_n != `ACCESS_IDLE;   // Writes finish at once

endmodule

`default_nettype wire

// ==== rtl/gpio_ctrl.sv ====
// GPIO output and input registers, pin function selects, audio select and pin output mux
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module gpio_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_bus_pkg::slot_req_t   i_req,
    output periph_bus_pkg::periph_rsp_t o_rsp,
    input  logic [7:0]                  i_ui_in,
    input  periph_map_pkg::pin_src_t    i_pins,
    output logic [`PIN_COUNT-1:0]       o_uo_out,
    output logic                        o_audio_select
);

    logic [`PIN_COUNT-1:0]  gpio_out;
    periph_map_pkg::fsel_t  fsel [`PIN_COUNT];
    logic [2:0]             audio_sel;
    logic                   wr;
    logic                   rd;
    logic                   fsel_hit;
    logic [2:0]             fsel_idx;

    assign wr = i_req.write_n != `ACCESS_IDLE;
    assign rd = i_req.read_n != `ACCESS_IDLE;

    // Selects sit on word offsets 0x20 to 0x3c
    assign fsel_hit = (i_req.ofs & 6'h23) == `GPIO_OFS_FSEL_BASE;
    assign fsel_idx = i_req.ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            for (int i = 0; i < `PIN_COUNT; i++) begin
                fsel[i] <= (i < 2) ? `FSEL_RESET_LOW : `FSEL_RESET_HIGH;
            end
        end else if (wr) begin
            if (i_req.ofs == `GPIO_OFS_OUT) gpio_out <= i_req.data[`PIN_COUNT-1:0];
            if (i_req.ofs == `GPIO_OFS_AUDIO) audio_sel <= i_req.data[2:0];
            if (fsel_hit) fsel[fsel_idx] <= periph_map_pkg::fsel_t'(i_req.data[4:0]);
        end
    end

    // Register readback
    always_comb begin
        o_rsp.ready = 1'b1;
        o_rsp.data  = '0;
        if (rd) begin
            if (i_req.ofs == `GPIO_OFS_OUT) begin
                o_rsp.data = {{(`PERIPH_DATA_W-`PIN_COUNT){1'b0}}, gpio_out};
            end else if (i_req.ofs == `GPIO_OFS_IN) begin
                o_rsp.data = {{(`PERIPH_DATA_W-8){1'b0}}, i_ui_in};
            end else if (i_req.ofs == `GPIO_OFS_AUDIO) begin
                o_rsp.data = {{(`PERIPH_DATA_W-3){1'b0}}, audio_sel};
            end else if (fsel_hit) begin
                o_rsp.data = {{(`PERIPH_DATA_W-5){1'b0}}, fsel[fsel_idx]};
            end
        end
    end

    // Each pin takes its own bit from the selected source
    always_comb begin
        for (int i = 0; i < `PIN_COUNT; i++) begin
            o_uo_out[i] = 1'b0;   // Unpopulated source
            if (fsel[i].byte_sel) begin
                if (fsel[i].slot == 4'(`PERIPH_BYTE_PWM)) o_uo_out[i] = i_pins.pwm[i];
            end else if (fsel[i].slot == 4'(`PERIPH_SLOT_GPIO)) begin
                o_uo_out[i] = gpio_out[i];
            end else if (fsel[i].slot == 4'(`PERIPH_SLOT_MUL)) begin
                o_uo_out[i] = i_pins.mul[i];
            end
        end
    end

    assign o_audio_select = audio_sel[2];

endmodule

`default_nettype wire

// ==== rtl/mul_unit.sv ====
// Iterative shift-add multiplier peripheral with busy stall and done interrupt
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module mul_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_bus_pkg::slot_req_t   i_req,
    output periph_bus_pkg::periph_rsp_t o_rsp,
    output logic [`PIN_COUNT-1:0]       o_pins,
    output logic                        o_irq
);

    logic [`MUL_OP_W-1:0]   op_a;
    logic [`MUL_OP_W-1:0]   op_b;
    logic [2*`MUL_OP_W-1:0] product;
    logic [3:0]             step;       // Bit of B being added in
    logic                   busy;
    logic                   irq;
    logic                   wr;
    logic                   rd;

    assign wr = i_req.write_n != `ACCESS_IDLE;
    assign rd = i_req.read_n != `ACCESS_IDLE;

    // Operands are frozen while a product is in progress
    always_ff @(posedge clk) begin
        if (wr && !busy) begin
            if (i_req.ofs == `MUL_OFS_A) op_a <= i_req.data[`MUL_OP_W-1:0];
            if (i_req.ofs == `MUL_OFS_B) op_b <= i_req.data[`MUL_OP_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            product <= '0;
            step    <= '0;
            busy    <= 1'b0;
            irq     <= 1'b0;
        end else if (busy) begin
            if (op_b[step]) product <= product + ({{`MUL_OP_W{1'b0}}, op_a} << step);
            step <= step + 4'd1;
            if (step == 4'(`MUL_OP_W-1)) begin
                busy <= 1'b0;
                irq  <= 1'b1;   // Product done
            end
        end else if (wr && i_req.ofs == `MUL_OFS_B) begin
            product <= '0;      // Writing B starts a new product
            step    <= '0;
            busy    <= 1'b1;
            irq     <= 1'b0;
        end else if (rd && i_req.ofs == `MUL_OFS_P) begin
            irq <= 1'b0;        // Cleared by reading the product
        end
    end

    always_comb begin
        o_rsp.ready = !(busy && i_req.ofs == `MUL_OFS_P);   // Stall product reads
        o_rsp.data  = '0;
        if (rd) begin
            if (i_req.ofs == `MUL_OFS_A) o_rsp.data = {{`MUL_OP_W{1'b0}}, op_a};
            if (i_req.ofs == `MUL_OFS_B) o_rsp.data = {{`MUL_OP_W{1'b0}}, op_b};
            if (i_req.ofs == `MUL_OFS_P) o_rsp.data = product;
        end
    end

    assign o_pins = product[`PIN_COUNT-1:0];
    assign o_irq  = irq;

endmodule

`default_nettype wire

// ==== rtl/pwm_byte.sv ====
// 8-bit duty PWM on a byte slot
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module pwm_byte (
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_bus_pkg::slot_req_t   i_req,
    output periph_bus_pkg::periph_rsp_t o_rsp,
    output logic [`PIN_COUNT-1:0]       o_pins
);

    logic [7:0] cnt;        // Free running, wraps every 256 cycles
    logic [7:0] duty;
    logic       pwm_out;
    logic       duty_hit;

    assign duty_hit = i_req.ofs == '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= '0;
            duty    <= '0;
            pwm_out <= 1'b0;
        end else begin
            cnt     <= cnt + 8'd1;
            pwm_out <= cnt < duty;   // High for duty cycles of every window
            if (i_req.write_n != `ACCESS_IDLE && duty_hit) duty <= i_req.data[7:0];
        end
    end

    // Byte slot answers at once, zero extended
    always_comb begin
        o_rsp.ready = 1'b1;
        o_rsp.data  = '0;
        if (i_req.read_n != `ACCESS_IDLE && duty_hit) begin
            o_rsp.data = {{(`PERIPH_DATA_W-8){1'b0}}, duty};
        end
    end

    assign o_pins = {`PIN_COUNT{pwm_out}};

endmodule

`default_nettype wire

// ==== rtl/periph_top.sv ====
// Peripheral wrapper top with decoder, GPIO, multiplier and PWM
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module periph_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [7:0]                i_ui_in,
    output logic [`PIN_COUNT-1:0]     o_uo_out,
    output logic                      o_audio,
    output logic                      o_audio_select,
    input  logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  logic [`PERIPH_DATA_W-1:0] i_data,
    input  periph_bus_pkg::access_n_t i_write_n,
    input  periph_bus_pkg::access_n_t i_read_n,
    output logic [`PERIPH_DATA_W-1:0] o_data,
    output logic                      o_data_ready,
    input  logic                      i_read_complete,
    output logic                      o_irq
);

    periph_bus_pkg::bus_req_t    bus_req;
    periph_bus_pkg::slot_req_t   gpio_req;
    periph_bus_pkg::slot_req_t   mul_req;
    periph_bus_pkg::slot_req_t   pwm_req;
    periph_bus_pkg::periph_rsp_t gpio_rsp;
    periph_bus_pkg::periph_rsp_t mul_rsp;
    periph_bus_pkg::periph_rsp_t pwm_rsp;
    periph_map_pkg::pin_src_t    pins;
    logic [`PIN_COUNT-1:0]       mul_pins;
    logic [`PIN_COUNT-1:0]       pwm_pins;

    assign bus_req.addr    = i_addr;
    assign bus_req.data    = i_data;
    assign bus_req.write_n = i_write_n;
    assign bus_req.read_n  = i_read_n;

    assign pins.mul = mul_pins;
    assign pins.pwm = pwm_pins;

    periph_decode u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (bus_req),
        .i_read_complete (i_read_complete),
        .o_gpio_req      (gpio_req),
        .o_mul_req       (mul_req),
        .o_pwm_req       (pwm_req),
        .i_gpio_rsp      (gpio_rsp),
        .i_mul_rsp       (mul_rsp),
        .i_pwm_rsp       (pwm_rsp),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (gpio_req),
        .o_rsp          (gpio_rsp),
        .i_ui_in        (i_ui_in),
        .i_pins         (pins),
        .o_uo_out       (o_uo_out),
        .o_audio_select (o_audio_select)
    );

    mul_unit u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_req  (mul_req),
        .o_rsp  (mul_rsp),
        .o_pins (mul_pins),
        .o_irq  (o_irq)
    );

    pwm_byte u_pwm (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_req  (pwm_req),
        .o_rsp  (pwm_rsp),
        .o_pins (pwm_pins)
    );

    assign o_audio = pwm_pins[`PIN_COUNT-1];   // PWM doubles as audio

endmodule

`default_nettype wire

// ==== tb/periph_props.sv ====
// Bound assertions with shadow registers for the bus handshake, GPIO, multiplier and PWM
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module periph_props (
    input logic                      clk,
    input logic                      rst_n,
    input logic [7:0]                i_ui_in,
    input logic [`PIN_COUNT-1:0]     o_uo_out,
    input logic                      o_audio,
    input logic                      o_audio_select,
    input logic [`PERIPH_ADDR_W-1:0] i_addr,
    input logic [`PERIPH_DATA_W-1:0] i_data,
    input logic [1:0]                i_write_n,
    input logic [1:0]                i_read_n,
    input logic [`PERIPH_DATA_W-1:0] o_data,
    input logic                      o_data_ready,
    input logic                      i_read_complete,
    input logic                      o_irq
);

    int                         fail_count = 0;     // Failed assertions so far
    logic                       wr;
    logic                       rd;
    logic [5:0]                 ofs;
    logic                       gpio_acc;
    logic                       mul_acc;
    logic                       pwm_acc;
    logic                       fsel_acc;
    logic                       ready_e;
    logic [7:0]                 gpio_s;
    logic [4:0]                 fsel_s [`PIN_COUNT];
    logic [2:0]                 audio_s;
    logic [`MUL_OP_W-1:0]       a_s;
    logic [2*`MUL_OP_W-1:0]     prod_s;
    logic [4:0]                 busy_cnt;           // Steps left in the product
    logic                       irq_s;
    logic                       hold_s;
    logic                       rd_q;
    logic [7:0]                 duty_s;
    logic [1:0]                 settle;
    logic [7:0]                 win_cnt;
    logic [8:0]                 high_cnt;
    logic [8:0]                 win_total;
    logic                       win_done;
    logic [`PERIPH_DATA_W-1:0]  exp_data;
    logic [`PIN_COUNT-1:0]      exp_pins;
    logic [`PIN_COUNT-1:0]      pin_mask;

    assign wr       = i_write_n != `ACCESS_IDLE;
    assign rd       = i_read_n != `ACCESS_IDLE;
    assign ofs      = i_addr[5:0];
    assign gpio_acc = !i_addr[10] && i_addr[9:6] == 4'(`PERIPH_SLOT_GPIO);
    assign mul_acc  = !i_addr[10] && i_addr[9:6] == 4'(`PERIPH_SLOT_MUL);
    assign pwm_acc  = i_addr[10] && i_addr[7:4] == 4'(`PERIPH_BYTE_PWM);
    assign fsel_acc = ofs[5] && ofs[1:0] == 2'b00;  // 0x20 + 4n
    assign ready_e  = !(mul_acc && ofs == `MUL_OFS_P && busy_cnt != 0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_s   <= '0;
            audio_s  <= '0;
            a_s      <= '0;
            prod_s   <= '0;
            busy_cnt <= '0;
            irq_s    <= 1'b0;
            hold_s   <= 1'b0;
            rd_q     <= 1'b0;
            duty_s   <= '0;
            settle   <= 2'd2;
            win_cnt  <= '0;
            high_cnt <= '0;
            win_total <= '0;
            win_done <= 1'b0;
            for (int i = 0; i < `PIN_COUNT; i++) begin
                fsel_s[i] <= (i < 2) ? 5'(`PERIPH_SLOT_MUL) : 5'(`PERIPH_SLOT_GPIO);
            end
        end else begin
            rd_q <= rd;
            if (i_read_complete) hold_s <= 1'b0;
            if (rd && !hold_s && ready_e) hold_s <= 1'b1;
            if (wr && gpio_acc) begin
                if (ofs == `GPIO_OFS_OUT) gpio_s <= i_data[7:0];
                if (ofs == `GPIO_OFS_AUDIO) audio_s <= i_data[2:0];
                if (fsel_acc) fsel_s[ofs[4:2]] <= i_data[4:0];
            end
            // Multiplier model, 16 steps from the write of B
            if (busy_cnt != 0) begin
                busy_cnt <= busy_cnt - 5'd1;
                if (busy_cnt == 5'd1) irq_s <= 1'b1;
            end else if (wr && mul_acc && ofs == `MUL_OFS_B) begin
                prod_s   <= a_s * i_data[`MUL_OP_W-1:0];
                busy_cnt <= 5'd16;
                irq_s    <= 1'b0;
            end else if (rd && mul_acc && ofs == `MUL_OFS_P && !hold_s) begin
                irq_s <= 1'b0;
            end
            if (wr && mul_acc && busy_cnt == 0 && ofs == `MUL_OFS_A) begin
                a_s <= i_data[`MUL_OP_W-1:0];
            end
            // PWM high count over 256-cycle windows
            if (wr && pwm_acc && i_addr[3:0] == 4'h0) begin
                duty_s   <= i_data[7:0];
                settle   <= 2'd2;
                win_cnt  <= '0;
                high_cnt <= '0;
                win_done <= 1'b0;
            end else if (settle != 0) begin
                settle <= settle - 2'd1;
            end else if (win_cnt == 8'd255) begin
                win_total <= high_cnt + 9'(o_audio);
                win_done  <= 1'b1;
                win_cnt   <= '0;
                high_cnt  <= '0;
            end else begin
                win_cnt  <= win_cnt + 8'd1;
                high_cnt <= high_cnt + 9'(o_audio);
                win_done <= 1'b0;
            end
        end
    end

    always_comb begin
        exp_data = '0;
        if (gpio_acc) begin
            if (ofs == `GPIO_OFS_OUT) exp_data = 32'(gpio_s);
            else if (ofs == `GPIO_OFS_IN) exp_data = 32'(i_ui_in);
            else if (ofs == `GPIO_OFS_AUDIO) exp_data = 32'(audio_s);
            else if (fsel_acc) exp_data = 32'(fsel_s[ofs[4:2]]);
        end else if (mul_acc && ofs == `MUL_OFS_P) begin
            exp_data = prod_s;
        end else if (mul_acc && ofs == `MUL_OFS_A) begin
            exp_data = 32'(a_s);
        end else if (pwm_acc && i_addr[3:0] == 4'h0) begin
            exp_data = 32'(duty_s);
        end
    end

    // Expected pins, multiplier pins ignored mid product
    always_comb begin
        for (int i = 0; i < `PIN_COUNT; i++) begin
            exp_pins[i] = 1'b0;
            pin_mask[i] = 1'b1;
            if (fsel_s[i][4]) begin
                if (fsel_s[i][3:0] == 4'(`PERIPH_BYTE_PWM)) exp_pins[i] = o_audio;
            end else if (fsel_s[i][3:0] == 4'(`PERIPH_SLOT_GPIO)) begin
                exp_pins[i] = gpio_s[i];
            end else if (fsel_s[i][3:0] == 4'(`PERIPH_SLOT_MUL)) begin
                exp_pins[i] = prod_s[i];
                pin_mask[i] = busy_cnt == 0;
            end
        end
    end

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (rd && !wr && $rose(o_data_ready)) |-> o_data == exp_data)
        else begin
            fail_count++;
            $error("ERROR o_data expected %h got %h", $sampled(exp_data), $sampled(o_data));
        end

    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
        (rd && o_data_ready) |=> (!rd || $stable(o_data)))
        else begin
            fail_count++;
            $error("ERROR o_data changed before read complete, now %h", $sampled(o_data));
        end

    a_write_ready: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> o_data_ready)
        else begin
            fail_count++;
            $error("Write was not acknowledged in its own cycle");
        end

    a_ready_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (rd && !rd_q && !mul_acc) |=> $rose(o_data_ready))
        else begin
            fail_count++;
            $error("Read data did not become ready exactly one cycle after the read began");
        end

    a_pins: assert property (@(posedge clk) disable iff (!rst_n)
        ((o_uo_out ^ exp_pins) & pin_mask) == '0)
        else begin
            fail_count++;
            $error("ERROR o_uo_out expected %h got %h mask %h", $sampled(exp_pins),
                   $sampled(o_uo_out), $sampled(pin_mask));
        end

    a_irq: assert property (@(posedge clk) disable iff (!rst_n)
        o_irq == irq_s)
        else begin
            fail_count++;
            $error("ERROR o_irq expected %h got %h", $sampled(irq_s), $sampled(o_irq));
        end

    a_audio_select: assert property (@(posedge clk) disable iff (!rst_n)
        o_audio_select == audio_s[2])
        else begin
            fail_count++;
            $error("ERROR o_audio_select expected %h got %h", $sampled(audio_s[2]),
                   $sampled(o_audio_select));
        end

    a_pwm_window: assert property (@(posedge clk) disable iff (!rst_n)
        win_done |-> win_total == 9'(duty_s))
        else begin
            fail_count++;
            $error("ERROR o_audio high count expected %h got %h", $sampled(duty_s),
                   $sampled(win_total));
        end

endmodule

`default_nettype wire

// ==== tb/periph_tb.sv ====
// Testbench for the peripheral wrapper with clock, reset, bus tasks, timeout and final report
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module periph_tb;

    // Whole run is about 1400 cycles
    localparam int CYCLE_LIMIT = 4000;
    localparam logic [10:0] GPIO_BASE = 11'(`PERIPH_SLOT_GPIO << `PERIPH_SLOT_OFS_W);
    localparam logic [10:0] MUL_BASE  = 11'(`PERIPH_SLOT_MUL << `PERIPH_SLOT_OFS_W);
    localparam logic [10:0] PWM_BASE  = 11'h400 | 11'(`PERIPH_BYTE_PWM << `PERIPH_BYTE_OFS_W);

    logic                      clk;
    logic                      rst_n;
    logic [7:0]                i_ui_in;
    logic [`PIN_COUNT-1:0]     o_uo_out;
    logic                      o_audio;
    logic                      o_audio_select;
    logic [`PERIPH_ADDR_W-1:0] i_addr;
    logic [`PERIPH_DATA_W-1:0] i_data;
    logic [1:0]                i_write_n;
    logic [1:0]                i_read_n;
    logic [`PERIPH_DATA_W-1:0] o_data;
    logic                      o_data_ready;
    logic                      i_read_complete;
    logic                      o_irq;
    int                        seed = 32'hab35_3488;
    int                        cycles = 0;

    periph_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .o_uo_out        (o_uo_out),
        .o_audio         (o_audio),
        .o_audio_select  (o_audio_select),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .i_read_complete (i_read_complete),
        .o_irq           (o_irq)
    );

    bind periph_top periph_props u_props (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .o_uo_out        (o_uo_out),
        .o_audio         (o_audio),
        .o_audio_select  (o_audio_select),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .i_read_complete (i_read_complete),
        .o_irq           (o_irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    // Word write, acknowledged in its own cycle
    task automatic bus_write(input logic [10:0] addr, input logic [31:0] data);
        @(posedge clk);
        i_addr    <= addr;
        i_data    <= data;
        i_write_n <= 2'b10;
        @(posedge clk);
        i_write_n <= 2'b11;
    endtask

    // Word read, held for extra cycles before completion while i_ui_in moves on
    task automatic bus_read(input logic [10:0] addr, input int extra);
        @(posedge clk);
        i_addr   <= addr;
        i_read_n <= 2'b10;
        do @(negedge clk); while (!o_data_ready);
        repeat (extra) begin
            @(posedge clk);
            i_ui_in <= 8'($random(seed));   // Held data must not follow the input
        end
        @(posedge clk);
        i_read_n        <= 2'b11;
        i_read_complete <= 1'b1;
        @(posedge clk);
        i_read_complete <= 1'b0;
    endtask

    initial begin
        logic [15:0] op_a;
        logic [15:0] op_b;
        rst_n           = 1'b0;
        i_ui_in         = 8'($random(seed));
        i_addr          = '0;
        i_data          = '0;
        i_write_n       = 2'b11;
        i_read_n        = 2'b11;
        i_read_complete = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // GPIO output and input readback
        bus_write(GPIO_BASE + `GPIO_OFS_OUT, 32'($random(seed)));
        bus_read(GPIO_BASE + `GPIO_OFS_OUT, 0);
        bus_read(GPIO_BASE + `GPIO_OFS_IN, 2);

        // Random products, pins 0 and 1 still on the multiplier
        repeat (4) begin
            op_a = 16'($random(seed));
            op_b = 16'($random(seed));
            bus_write(MUL_BASE + `MUL_OFS_A, 32'(op_a));
            bus_write(MUL_BASE + `MUL_OFS_B, 32'(op_b));
            bus_read(MUL_BASE + `MUL_OFS_P, 2);
            bus_read(MUL_BASE + `MUL_OFS_A, 0);
            repeat (3) @(posedge clk);
        end

        // Function selects from reset, then new sources
        for (int n = 0; n < `PIN_COUNT; n++) bus_read(GPIO_BASE + 11'h20 + 11'(4 * n), 0);
        bus_write(GPIO_BASE + 11'h20, 32'h01);
        bus_write(GPIO_BASE + 11'h28, 32'h02);
        bus_write(GPIO_BASE + 11'h2c, 32'h10);
        bus_write(GPIO_BASE + 11'h30, 32'h05);
        bus_write(GPIO_BASE + 11'h34, 32'h13);
        for (int n = 0; n < `PIN_COUNT; n++) bus_read(GPIO_BASE + 11'h20 + 11'(4 * n), 0);
        bus_write(GPIO_BASE + `GPIO_OFS_AUDIO, 32'h4);
        bus_read(GPIO_BASE + `GPIO_OFS_AUDIO, 0);
        bus_write(GPIO_BASE + `GPIO_OFS_OUT, 32'($random(seed)));

        // PWM duty, two full windows each
        bus_write(PWM_BASE, 32'(8'($random(seed)) | 8'h01));
        bus_read(PWM_BASE, 0);
        repeat (600) @(posedge clk);
        bus_write(PWM_BASE, 32'h0000_00c3);
        bus_read(PWM_BASE, 1);
        repeat (600) @(posedge clk);

        // Unpopulated slots
        bus_read(11'h0c0, 3);
        bus_read(11'h410, 3);
        bus_read(11'h7f0, 0);

        repeat (4) @(posedge clk);
        $display("Assertion failures: %0d in %0d cycles", dut0.u_props.fail_count, cycles);
        if (dut0.u_props.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/periph_bus_pkg.sv
rtl/periph_map_pkg.sv
rtl/periph_decode.sv
rtl/gpio_ctrl.sv
rtl/mul_unit.sv
rtl/pwm_byte.sv
rtl/periph_top.sv
tb/periph_props.sv
tb/periph_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert --timing
TOP        ?= periph_tb
FILELIST   ?= tb.f
LOG        ?= sim.log
PASS_MSG   := Verification passed
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
